// ==== rv_id_stage.f ====
+incdir+source
source/rv_id_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_hazard_unit.sv
source/rv_operand_mux.sv
source/rv_id_ex_reg.sv
source/rv_id_stage.sv
verification/tb_rv_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_id_stage.f \
  --top-module tb_rv_id_stage -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0

// ==== verification/tb_rv_id_stage.sv ====
`include "rv_id_defines.svh"

module tb_rv_id_stage;

  localparam int WAIT_LIMIT = 50;

  logic                 clk;
  logic                 rst_n;
  logic                 if_valid_i;
  rv_id_pkg::if_id_t    if_i;
  logic                 if_ready_o;
  rv_id_pkg::rf_wr_t    ex_fwd_i;
  rv_id_pkg::rf_wr_t    wb_i;
  logic                 ex_valid_o;
  rv_id_pkg::id_ex_t    ex_o;
  logic                 ex_ready_i;

  // Reference state
  rv_id_pkg::word_t     shadow [0:31];
  rv_id_pkg::id_ex_t    exp_q [$];
  int                   acc_cnt;
  int                   errors;
  int                   checks;
  int                   tests;
  logic                 bp_mode;

  rv_id_stage dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_valid_i (if_valid_i),
    .if_i       (if_i),
    .if_ready_o (if_ready_o),
    .ex_fwd_i   (ex_fwd_i),
    .wb_i       (wb_i),
    .ex_valid_o (ex_valid_o),
    .ex_o       (ex_o),
    .ex_ready_i (ex_ready_i)
  );

  always #20 clk = ~clk;

  // Random back-pressure from EX
  always @(negedge clk) begin
    if (bp_mode) begin
      ex_ready_i = 1'($urandom_range(0, 1));
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  // Source registers read by each format as {rs1, rs2}
  function automatic logic [1:0] srcs_read(input rv_id_pkg::word_t instr);
    case (instr[6:0])
      `RV_OPC_OP, `RV_OPC_STORE, `RV_OPC_BRANCH: return 2'b11;
      `RV_OPC_OPIMM, `RV_OPC_LOAD, `RV_OPC_JALR: return 2'b10;
      default:                                    return 2'b00;
    endcase
  endfunction

  // Source value seen by ID with forwarding only when the format reads it
  function automatic rv_id_pkg::word_t src_val(input logic [4:0] rs, input logic used);
    if (rs == 5'd0) return '0;
    if (used && ex_fwd_i.we && ex_fwd_i.addr == rs) return ex_fwd_i.data;
    if (used && wb_i.we && wb_i.addr == rs) return wb_i.data;
    return shadow[rs];
  endfunction

  function automatic rv_id_pkg::id_ex_t ref_packet(input rv_id_pkg::word_t instr,
                                                   input rv_id_pkg::word_t pc);
    rv_id_pkg::id_ex_t p;
    rv_id_pkg::word_t  ii;
    rv_id_pkg::word_t  is;
    rv_id_pkg::word_t  ib;
    rv_id_pkg::word_t  iu;
    rv_id_pkg::word_t  ij;
    rv_id_pkg::word_t  v1;
    rv_id_pkg::word_t  v2;
    logic [1:0]        used;
    logic [2:0]        f3;
    ii   = rv_id_pkg::word_t'($signed(instr[31:20]));
    is   = rv_id_pkg::word_t'($signed({instr[31:25], instr[11:7]}));
    ib   = rv_id_pkg::word_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
    iu   = {instr[31:12], 12'h000};
    ij   = rv_id_pkg::word_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21],
                                       1'b0}));
    used = srcs_read(instr);
    f3   = instr[14:12];
    v1   = src_val(instr[19:15], used[1]);
    v2   = src_val(instr[24:20], used[0]);
    p        = '0;
    p.alu_op = rv_id_pkg::ALU_ADD;
    p.rd     = instr[11:7];
    p.pc     = pc;
    p.op_a   = v1;
    p.op_b   = ii;
    p.op_c   = v2;
    case (instr[6:0])
      `RV_OPC_OP, `RV_OPC_OPIMM: begin
        case (f3)
          3'd0: p.alu_op = (instr[30] && instr[5]) ? rv_id_pkg::ALU_SUB : rv_id_pkg::ALU_ADD;
          3'd1: p.alu_op = rv_id_pkg::ALU_SLL;
          3'd2: p.alu_op = rv_id_pkg::ALU_SLT;
          3'd3: p.alu_op = rv_id_pkg::ALU_SLTU;
          3'd4: p.alu_op = rv_id_pkg::ALU_XOR;
          3'd5: p.alu_op = instr[30] ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
          3'd6: p.alu_op = rv_id_pkg::ALU_OR;
          3'd7: p.alu_op = rv_id_pkg::ALU_AND;
        endcase
        if (instr[5]) p.op_b = v2;
        p.rf_we = 1'b1;
      end
      `RV_OPC_LOAD: begin
        p.rf_we        = 1'b1;
        p.mem_req      = 1'b1;
        p.mem_size     = f3[1:0];
        p.mem_unsigned = f3[2];
      end
      `RV_OPC_STORE: begin
        p.op_b     = is;
        p.mem_req  = 1'b1;
        p.mem_we   = 1'b1;
        p.mem_size = f3[1:0];
      end
      `RV_OPC_BRANCH: begin
        if (f3[2:1] == 2'b10) p.alu_op = rv_id_pkg::ALU_SLT;
        else if (f3[2:1] == 2'b11) p.alu_op = rv_id_pkg::ALU_SLTU;
        else p.alu_op = rv_id_pkg::ALU_SUB;
        p.op_b      = v2;
        p.op_c      = pc + ib;
        p.is_branch = 1'b1;
      end
      `RV_OPC_JAL: begin
        p.op_a    = pc;
        p.op_b    = 32'd4;
        p.op_c    = pc + ij;
        p.rf_we   = 1'b1;
        p.is_jump = 1'b1;
      end
      `RV_OPC_JALR: begin
        p.op_a    = pc;
        p.op_b    = 32'd4;
        p.op_c    = (v1 + ii) & ~32'd1;
        p.rf_we   = 1'b1;
        p.is_jump = 1'b1;
      end
      `RV_OPC_LUI: begin
        p.op_a  = '0;
        p.op_b  = iu;
        p.rf_we = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        p.op_a  = pc;
        p.op_b  = iu;
        p.rf_we = 1'b1;
      end
      default: p.illegal = 1'b1;
    endcase
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    logic       held;
    logic       stall;
    logic [1:0] used;
    if (rst_n) begin
      held  = (exp_q.size() > 0);
      used  = srcs_read(if_i.instr);
      stall = held && exp_q[0].mem_req && !exp_q[0].mem_we && (exp_q[0].rd != 5'd0) &&
              ((used[1] && if_i.instr[19:15] == exp_q[0].rd) ||
               (used[0] && if_i.instr[24:20] == exp_q[0].rd));
      checks += 2;
      assert (ex_valid_o == held) else begin
        $display("MISMATCH time=%0t signal=ex_valid_o expected=%b actual=%b",
                 $time, held, ex_valid_o);
        errors++;
      end
      assert (if_ready_o == !(stall || (held && !ex_ready_i))) else begin
        $display("MISMATCH time=%0t signal=if_ready_o expected=%b actual=%b",
                 $time, !(stall || (held && !ex_ready_i)), if_ready_o);
        errors++;
      end
      if (ex_valid_o && ex_ready_i && held) begin
        checks++;
        assert (ex_o == exp_q[0]) else begin
          $display("MISMATCH time=%0t signal=ex_o expected=%h actual=%h",
                   $time, exp_q[0], ex_o);
          errors++;
        end
        void'(exp_q.pop_front());
      end
      if (if_valid_i && if_ready_o) begin
        exp_q.push_back(ref_packet(if_i.instr, if_i.pc));
        acc_cnt++;
      end
      if (wb_i.we && wb_i.addr != 5'd0) shadow[wb_i.addr] = wb_i.data;
    end
  end

  // Held packet stays put under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
                   (ex_valid_o && !ex_ready_i) |=> (ex_valid_o && $stable(ex_o)))
  else begin
    $display("ex_o or ex_valid_o changed while EX was not ready, time %0t", $time);
    errors++;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic timeout_fail(input string what);
    $display("Timeout while waiting: %s, time %0t", what, $time);
    $display("TEST FAILED");
    $finish;
  endtask

  // Called on a falling edge and holds the instruction until it is taken
  task automatic send(input rv_id_pkg::word_t instr, input rv_id_pkg::word_t pc,
                      input rv_id_pkg::rf_wr_t exf, input rv_id_pkg::rf_wr_t wbw);
    int start;
    int n;
    start      = acc_cnt;
    n          = 0;
    if_valid_i = 1'b1;
    if_i       = '{instr: instr, pc: pc};
    ex_fwd_i   = exf;
    wb_i       = wbw;
    while (acc_cnt == start) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timeout_fail("instruction accept");
    end
    if_valid_i = 1'b0;
    ex_fwd_i   = '0;
    wb_i       = '0;
  endtask

  task automatic wb_write(input logic [4:0] addr, input rv_id_pkg::word_t data);
    wb_i = '{we: 1'b1, addr: addr, data: data};
    @(negedge clk);
    wb_i = '0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timeout_fail("pipeline drain");
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - err_before);
  endtask

  function automatic rv_id_pkg::word_t rand_instr(input logic [6:0] opc);
    return {$urandom()} & 32'hffff_ff80 | {25'd0, opc};
  endfunction

  initial begin
    logic [6:0]  opcs [0:7];
    logic [6:0]  mix [0:9];
    rv_id_pkg::word_t instr;
    rv_id_pkg::rf_wr_t fa;
    rv_id_pkg::rf_wr_t fb;
    int          e0;
    void'($urandom(32'hc018));
    opcs = '{`RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_BRANCH, `RV_OPC_JAL, `RV_OPC_JALR,
             `RV_OPC_LUI, `RV_OPC_AUIPC, 7'b1111111};
    mix  = '{`RV_OPC_OP, `RV_OPC_OPIMM, `RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_BRANCH,
             `RV_OPC_JAL, `RV_OPC_JALR, `RV_OPC_LUI, `RV_OPC_AUIPC, 7'b0001011};
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    clk = 1'b0;
    rst_n = 1'b0;
    if_valid_i = 1'b0;
    if_i = '0;
    ex_fwd_i = '0;
    wb_i = '0;
    ex_ready_i = 1'b1;
    bp_mode = 1'b0;
    acc_cnt = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    e0 = errors;
    @(negedge clk);
    checks++;
    assert (!ex_valid_o && if_ready_o && !ex_o.rf_we && !ex_o.mem_req && !ex_o.illegal)
    else begin
      $display("Stage not idle after reset, time %0t", $time);
      errors++;
    end
    report("reset", e0);

    // Register fill with an ignored x0 write before the ALU formats
    e0 = errors;
    for (int r = 0; r < 32; r++) wb_write(5'(r), $urandom());
    for (int i = 0; i < 40; i++) begin
      instr = rand_instr((i % 2) ? `RV_OPC_OP : `RV_OPC_OPIMM);
      if (i % 2) instr[31:25] = {1'b0, instr[30], 5'd0};
      if (i % 8 == 0) instr[19:15] = 5'd0;
      send(instr, $urandom() & ~32'd3, '0, '0);
    end
    drain();
    report("alu formats", e0);

    // Other formats and an unknown opcode
    e0 = errors;
    for (int i = 0; i < 48; i++) begin
      send(rand_instr(opcs[i % 8]), $urandom() & ~32'd3, '0, '0);
    end
    drain();
    report("other formats", e0);

    // Forwarding priority
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      instr = rand_instr(`RV_OPC_OP);
      instr[31:25] = 7'd0;
      instr[19:15] = 5'(1 + i);
      fa = '{we: 1'b1, addr: instr[19:15], data: $urandom()};
      fb = '{we: 1'b1, addr: instr[19:15], data: $urandom()};
      send(instr, 32'h100, fa, fb);
      // WB value differs from the one now in the RF
      fb.data = $urandom();
      send(instr, 32'h104, '0, fb);
    end
    drain();
    report("forwarding", e0);

    // Load-use stall before WB supplies the load data
    e0 = errors;
    ex_ready_i = 1'b0;
    send({12'h010, 5'd0, 3'b010, 5'd5, `RV_OPC_LOAD}, 32'h200, '0, '0);
    if_valid_i = 1'b1;
    if_i = '{instr: {7'd0, 5'd7, 5'd5, 3'd0, 5'd9, `RV_OPC_OP}, pc: 32'h204};
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (!if_ready_o) else begin
        $display("Dependent instruction not held behind the load, time %0t", $time);
        errors++;
      end
    end
    ex_ready_i = 1'b1;
    @(negedge clk);
    send(if_i.instr, if_i.pc, '0, '{we: 1'b1, addr: 5'd5, data: 32'hfeed_0005});
    drain();
    report("load use", e0);

    // Random back-pressure on a mixed stream
    e0 = errors;
    bp_mode = 1'b1;
    for (int i = 0; i < 60; i++) begin
      send(rand_instr(mix[$urandom_range(0, 9)]), $urandom() & ~32'd3, '0, '0);
    end
    drain();
    bp_mode = 1'b0;
    @(negedge clk);
    ex_ready_i = 1'b1;
    report("back pressure", e0);

    @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== source/rv_id_stage.sv ====
`include "rv_id_defines.svh"

module rv_id_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              if_valid_i,
  input  rv_id_pkg::if_id_t if_i,
  output logic              if_ready_o,
  input  rv_id_pkg::rf_wr_t ex_fwd_i,
  input  rv_id_pkg::rf_wr_t wb_i,
  output logic              ex_valid_o,
  output rv_id_pkg::id_ex_t ex_o,
  input  logic              ex_ready_i
);

  rv_id_pkg::reg_addr_t rs1;
  rv_id_pkg::reg_addr_t rs2;
  rv_id_pkg::dec_ctrl_t ctrl;
  rv_id_pkg::word_t     rf_a;
  rv_id_pkg::word_t     rf_b;
  rv_id_pkg::fwd_sel_e  fwd_a;
  rv_id_pkg::fwd_sel_e  fwd_b;
  logic                 stall;
  logic                 ex_is_load;
  rv_id_pkg::word_t     op_a;
  rv_id_pkg::word_t     op_b;
  rv_id_pkg::word_t     op_c;
  rv_id_pkg::id_ex_t    pkt;

  assign rs1 = if_i.instr[`RV_RS1_MSB:`RV_RS1_LSB];
  assign rs2 = if_i.instr[`RV_RS2_MSB:`RV_RS2_LSB];

  // Load still sitting in ID/EX
  assign ex_is_load = ex_o.mem_req && !ex_o.mem_we;

  rv_decoder decoder0 (
    .instr_i (if_i.instr),
    .ctrl_o  (ctrl)
  );

  rv_regfile regfile0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .wr_i      (wb_i)
  );

  rv_hazard_unit hazard0 (
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .ctrl_i       (ctrl),
    .ex_fwd_i     (ex_fwd_i),
    .wb_i         (wb_i),
    .ex_valid_i   (ex_valid_o),
    .ex_load_rd_i (ex_o.rd),
    .ex_is_load_i (ex_is_load),
    .fwd_a_o      (fwd_a),
    .fwd_b_o      (fwd_b),
    .stall_o      (stall)
  );

  rv_operand_mux opmux0 (
    .pc_i      (if_i.pc),
    .ctrl_i    (ctrl),
    .rf_a_i    (rf_a),
    .rf_b_i    (rf_b),
    .ex_data_i (ex_fwd_i.data),
    .wb_data_i (wb_i.data),
    .fwd_a_i   (fwd_a),
    .fwd_b_i   (fwd_b),
    .op_a_o    (op_a),
    .op_b_o    (op_b),
    .op_c_o    (op_c)
  );

  ////////////////////////////////////////////////////////////
  // Packet to EX
  ////////////////////////////////////////////////////////////
  always_comb begin
    pkt.alu_op       = ctrl.alu_op;
    pkt.op_a         = op_a;
    pkt.op_b         = op_b;
    pkt.op_c         = op_c;
    pkt.rd           = ctrl.rd;
    pkt.rf_we        = ctrl.rf_we;
    pkt.mem_req      = ctrl.mem_req;
    pkt.mem_we       = ctrl.mem_we;
    pkt.mem_size     = ctrl.mem_size;
    pkt.mem_unsigned = ctrl.mem_unsigned;
    pkt.is_branch    = ctrl.is_branch;
    pkt.is_jump      = ctrl.is_jump;
    pkt.illegal      = ctrl.illegal;
    pkt.pc           = if_i.pc;
  end

  // Upstream ready comes straight from the pipeline register
  rv_id_ex_reg idex0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (if_valid_i),
    .in_ready_o  (if_ready_o),
    .stall_i     (stall),
    .pkt_i       (pkt),
    .out_valid_o (ex_valid_o),
    .out_ready_i (ex_ready_i),
    .pkt_o       (ex_o)
  );

endmodule

// ==== source/rv_id_ex_reg.sv ====
module rv_id_ex_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic              stall_i,
  input  rv_id_pkg::id_ex_t pkt_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output rv_id_pkg::id_ex_t pkt_o
);

  logic load;

  // Free slot, or the held packet leaves this cycle
  assign in_ready_o = !stall_i && (!out_valid_o || out_ready_i);
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      // Drained with nothing behind it
      out_valid_o <= 1'b0;
    end
  end

  // Packet held stable until EX takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_o <= '0;
    end else if (load) begin
      pkt_o <= pkt_i;
    end
  end

endmodule

// ==== source/rv_operand_mux.sv ====
module rv_operand_mux (
  input  rv_id_pkg::word_t     pc_i,
  input  rv_id_pkg::dec_ctrl_t ctrl_i,
  input  rv_id_pkg::word_t     rf_a_i,
  input  rv_id_pkg::word_t     rf_b_i,
  input  rv_id_pkg::word_t     ex_data_i,
  input  rv_id_pkg::word_t     wb_data_i,
  input  rv_id_pkg::fwd_sel_e  fwd_a_i,
  input  rv_id_pkg::fwd_sel_e  fwd_b_i,
  output rv_id_pkg::word_t     op_a_o,
  output rv_id_pkg::word_t     op_b_o,
  output rv_id_pkg::word_t     op_c_o
);

  rv_id_pkg::word_t rs1_val;
  rv_id_pkg::word_t rs2_val;
  rv_id_pkg::word_t jalr_sum;

  function automatic rv_id_pkg::word_t fwd_pick(
    input rv_id_pkg::fwd_sel_e sel,
    input rv_id_pkg::word_t    rf,
    input rv_id_pkg::word_t    ex,
    input rv_id_pkg::word_t    wb
  );
    rv_id_pkg::word_t val;
    case (sel)
      rv_id_pkg::FWD_EX: val = ex;
      rv_id_pkg::FWD_WB: val = wb;
      default:           val = rf;
    endcase
    return val;
  endfunction

  ////////////////////////////////////////////////////////////
  // Forwarded sources
  ////////////////////////////////////////////////////////////
  assign rs1_val = fwd_pick(fwd_a_i, rf_a_i, ex_data_i, wb_data_i);
  assign rs2_val = fwd_pick(fwd_b_i, rf_b_i, ex_data_i, wb_data_i);

  // JALR target before LSB clear
  assign jalr_sum = rs1_val + ctrl_i.imm;

  always_comb begin
    case (ctrl_i.op_a_sel)
      rv_id_pkg::OP_A_PC:   op_a_o = pc_i;
      rv_id_pkg::OP_A_ZERO: op_a_o = '0;
      default:              op_a_o = rs1_val;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_b_sel)
      rv_id_pkg::OP_B_IMM: op_b_o = ctrl_i.imm;
      // Link offset
      rv_id_pkg::OP_B_PC4: op_b_o = rv_id_pkg::word_t'(4);
      default:             op_b_o = rs2_val;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_c_sel)
      rv_id_pkg::OP_C_PC_IMM:  op_c_o = pc_i + ctrl_i.imm;
      rv_id_pkg::OP_C_RS1_IMM: op_c_o = {jalr_sum[$bits(jalr_sum)-1:1], 1'b0};
      default:                 op_c_o = rs2_val;
    endcase
  end

endmodule

// ==== source/rv_hazard_unit.sv ====
module rv_hazard_unit (
  input  rv_id_pkg::reg_addr_t rs1_i,
  input  rv_id_pkg::reg_addr_t rs2_i,
  input  rv_id_pkg::dec_ctrl_t ctrl_i,
  input  rv_id_pkg::rf_wr_t    ex_fwd_i,
  input  rv_id_pkg::rf_wr_t    wb_i,
  input  logic                 ex_valid_i,
  input  rv_id_pkg::reg_addr_t ex_load_rd_i,
  input  logic                 ex_is_load_i,
  output rv_id_pkg::fwd_sel_e  fwd_a_o,
  output rv_id_pkg::fwd_sel_e  fwd_b_o,
  output logic                 stall_o
);

  logic load_hit_a;
  logic load_hit_b;

  // EX wins over WB, x0 and unused operands stay on the RF (reads zero)
  function automatic rv_id_pkg::fwd_sel_e pick_src(
    input rv_id_pkg::reg_addr_t rs,
    input logic                 used,
    input rv_id_pkg::rf_wr_t    ex,
    input rv_id_pkg::rf_wr_t    wb
  );
    rv_id_pkg::fwd_sel_e sel;
    sel = rv_id_pkg::FWD_RF;
    if (used && (rs != '0)) begin
      if (ex.we && (ex.addr == rs)) begin
        sel = rv_id_pkg::FWD_EX;
      end else if (wb.we && (wb.addr == rs)) begin
        sel = rv_id_pkg::FWD_WB;
      end
    end
    return sel;
  endfunction

  assign fwd_a_o = pick_src(rs1_i, ctrl_i.rs1_used, ex_fwd_i, wb_i);
  assign fwd_b_o = pick_src(rs2_i, ctrl_i.rs2_used, ex_fwd_i, wb_i);

  ////////////////////////////////////////////////////////////
  // Load-use detection
  ////////////////////////////////////////////////////////////
  // Load data only shows up on wb_i after the load leaves ID/EX
  assign load_hit_a = ctrl_i.rs1_used && (rs1_i == ex_load_rd_i);
  assign load_hit_b = ctrl_i.rs2_used && (rs2_i == ex_load_rd_i);

  assign stall_o = ex_valid_i && ex_is_load_i && (ex_load_rd_i != '0) &&
                   (load_hit_a || load_hit_b);

endmodule

// ==== source/rv_regfile.sv ====
`include "rv_id_defines.svh"

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_id_pkg::reg_addr_t raddr_a_i,
  input  rv_id_pkg::reg_addr_t raddr_b_i,
  output rv_id_pkg::word_t     rdata_a_o,
  output rv_id_pkg::word_t     rdata_b_o,
  input  rv_id_pkg::rf_wr_t    wr_i
);

  localparam int unsigned NUM_REGS = 1 << `RV_REG_AW;

  // x0 has no storage
  rv_id_pkg::word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.addr != '0)) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  // Asynchronous reads, no same-cycle write bypass
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== source/rv_decoder.sv ====
`include "rv_id_defines.svh"

module rv_decoder (
  input  rv_id_pkg::word_t     instr_i,
  output rv_id_pkg::dec_ctrl_t ctrl_o
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             funct7_alt;
  rv_id_pkg::word_t imm_i;
  rv_id_pkg::word_t imm_s;
  rv_id_pkg::word_t imm_b;
  rv_id_pkg::word_t imm_u;
  rv_id_pkg::word_t imm_j;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic rv_id_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    rv_id_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_id_pkg::ALU_SUB : rv_id_pkg::ALU_ADD;
      3'b001:  op = rv_id_pkg::ALU_SLL;
      3'b010:  op = rv_id_pkg::ALU_SLT;
      3'b011:  op = rv_id_pkg::ALU_SLTU;
      3'b100:  op = rv_id_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
      3'b110:  op = rv_id_pkg::ALU_OR;
      default: op = rv_id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode     = instr_i[`RV_OPC_MSB:`RV_OPC_LSB];
  assign funct3     = instr_i[14:12];
  assign funct7_alt = instr_i[30];

  ////////////////////////////////////////////////////////////
  // Sign extended immediates
  ////////////////////////////////////////////////////////////
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Defaults: reg + I-imm ADD, nothing written
    ctrl_o          = '0;
    ctrl_o.alu_op   = rv_id_pkg::ALU_ADD;
    ctrl_o.op_a_sel = rv_id_pkg::OP_A_REG;
    ctrl_o.op_b_sel = rv_id_pkg::OP_B_IMM;
    ctrl_o.op_c_sel = rv_id_pkg::OP_C_RS2;
    ctrl_o.imm      = imm_i;
    ctrl_o.rd       = instr_i[`RV_RD_MSB:`RV_RD_LSB];
    case (opcode)
      `RV_OPC_OP: begin
        ctrl_o.alu_op   = alu_from_f3(funct3, funct7_alt);
        ctrl_o.op_b_sel = rv_id_pkg::OP_B_REG;
        ctrl_o.rs1_used = 1'b1;
        ctrl_o.rs2_used = 1'b1;
        ctrl_o.rf_we    = 1'b1;
      end
      `RV_OPC_OPIMM: begin
        // Only SRAI uses bit 30, ADDI has no subtract
        ctrl_o.alu_op   = alu_from_f3(funct3, funct7_alt && (funct3 == 3'b101));
        ctrl_o.rs1_used = 1'b1;
        ctrl_o.rf_we    = 1'b1;
      end
      `RV_OPC_LOAD: begin
        ctrl_o.rs1_used     = 1'b1;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.mem_req      = 1'b1;
        ctrl_o.mem_size     = funct3[1:0];
        ctrl_o.mem_unsigned = funct3[2];
      end
      `RV_OPC_STORE: begin
        // Address from ALU, data on operand C
        ctrl_o.imm      = imm_s;
        ctrl_o.rs1_used = 1'b1;
        ctrl_o.rs2_used = 1'b1;
        ctrl_o.mem_req  = 1'b1;
        ctrl_o.mem_we   = 1'b1;
        ctrl_o.mem_size = funct3[1:0];
      end
      `RV_OPC_BRANCH: begin
        // BEQ/BNE subtract, BLT/BGE signed, BLTU/BGEU unsigned
        case (funct3[2:1])
          2'b10:   ctrl_o.alu_op = rv_id_pkg::ALU_SLT;
          2'b11:   ctrl_o.alu_op = rv_id_pkg::ALU_SLTU;
          default: ctrl_o.alu_op = rv_id_pkg::ALU_SUB;
        endcase
        ctrl_o.op_b_sel  = rv_id_pkg::OP_B_REG;
        ctrl_o.op_c_sel  = rv_id_pkg::OP_C_PC_IMM;
        ctrl_o.imm       = imm_b;
        ctrl_o.rs1_used  = 1'b1;
        ctrl_o.rs2_used  = 1'b1;
        ctrl_o.is_branch = 1'b1;
      end
      `RV_OPC_JAL: begin
        // Link value PC + 4 through the ALU
        ctrl_o.op_a_sel = rv_id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = rv_id_pkg::OP_B_PC4;
        ctrl_o.op_c_sel = rv_id_pkg::OP_C_PC_IMM;
        ctrl_o.imm      = imm_j;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
      end
      `RV_OPC_JALR: begin
        ctrl_o.op_a_sel = rv_id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = rv_id_pkg::OP_B_PC4;
        ctrl_o.op_c_sel = rv_id_pkg::OP_C_RS1_IMM;
        ctrl_o.rs1_used = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
      end
      `RV_OPC_LUI: begin
        ctrl_o.op_a_sel = rv_id_pkg::OP_A_ZERO;
        ctrl_o.imm      = imm_u;
        ctrl_o.rf_we    = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        ctrl_o.op_a_sel = rv_id_pkg::OP_A_PC;
        ctrl_o.imm      = imm_u;
        ctrl_o.rf_we    = 1'b1;
      end
      default: begin
        // Unknown opcode, no side effects downstream
        ctrl_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== source/rv_id_pkg.sv ====
`include "rv_id_defines.svh"

package rv_id_pkg;

  // Data or address word
  typedef logic [`RV_XLEN-1:0]   word_t;
  // Register index
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // ALU operation, branch compares reuse SUB, SLT and SLTU
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_REG = 2'd0,
    OP_B_IMM = 2'd1,
    OP_B_PC4 = 2'd2
  } op_b_sel_e;

  // Store data, PC relative target or JALR target
  typedef enum logic [1:0] {
    OP_C_RS2     = 2'd0,
    OP_C_PC_IMM  = 2'd1,
    OP_C_RS1_IMM = 2'd2
  } op_c_sel_e;

  typedef enum logic [1:0] {
    FWD_RF = 2'd0,
    FWD_EX = 2'd1,
    FWD_WB = 2'd2
  } fwd_sel_e;

  // Fetched word and its PC
  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  // Register write, also a result in flight
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    word_t     imm;
    logic      rs1_used;
    logic      rs2_used;
    logic      rf_we;
    reg_addr_t rd;
    logic      mem_req;
    logic      mem_we;
    logic      [1:0] mem_size;
    logic      mem_unsigned;
    logic      is_branch;
    logic      is_jump;
    logic      illegal;
  } dec_ctrl_t;

  // Packet handed to EX
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    reg_addr_t rd;
    logic      rf_we;
    logic      mem_req;
    logic      mem_we;
    logic      [1:0] mem_size;
    logic      mem_unsigned;
    logic      is_branch;
    logic      is_jump;
    logic      illegal;
    word_t     pc;
  } id_ex_t;

endpackage

// ==== source/rv_id_defines.svh ====
`ifndef RV_ID_DEFINES_SVH
`define RV_ID_DEFINES_SVH

// Datapath and register index widths
`define RV_XLEN       32
`define RV_REG_AW     5

// Register and opcode fields of a 32-bit instruction
`define RV_RS1_MSB    19
`define RV_RS1_LSB    15
`define RV_RS2_MSB    24
`define RV_RS2_LSB    20
`define RV_RD_MSB     11
`define RV_RD_LSB     7
`define RV_OPC_MSB    6
`define RV_OPC_LSB    0

// RV32I base opcodes
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111

`endif
